/* compile.f */
rtl/canny_pkg.sv
rtl/frame_buffer.sv
rtl/scan_ctrl.sv
rtl/median_3x3.sv
rtl/sobel_edge.sv
rtl/canny_top.sv
tb/canny_assert.sv
tb/canny_tb.sv

/* Makefile */
# Verilator build and run of the edge detector testbench

VERILATOR ?= verilator
TOP ?= canny_tb
FILELIST ?= compile.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_MSG ?= STATUS: PASS

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tb/canny_tb.sv */
`timescale 1ns/10ps

module canny_tb;
	import canny_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int OUT_PIX = OUT_DIM * OUT_DIM;
	localparam int GROUPS = TOTAL_PIX / LOAD_LANES;
	// load, two passes of 18 bands and write-back fit well inside this
	localparam int NUM_FRAMES = 3;
	localparam int FRAME_CYCLES = 1500;
	localparam int CYCLE_LIMIT = NUM_FRAMES * FRAME_CYCLES + RESET_CYCLES;
	localparam logic [31:0] SEED = 32'h7fb4_cabd;

	logic clk;
	logic reset;
	pixel_lanes_t pixels;
	logic load_end;
	logic edge_out;
	logic readable;

	// stimulus image, model median plane and expected edge bits
	pixel_t image [TOTAL_PIX];
	int med [IMG_DIM][IMG_DIM];
	logic exp_bits [OUT_PIX];
	int exp_ones;
	int out_idx;
	int out_ones;
	logic [31:0] rng;
	int cycles;
	int value_errors;
	int count_errors;
	int protocol_errors;

	canny_top i_canny_top (
		.clk(clk),
		.reset(reset),
		.pixels(pixels),
		.load_end(load_end),
		.edge_out(edge_out),
		.readable(readable)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// border index maps to the nearest interior one
	function automatic int clamp_interior(input int idx);
		return (idx < 1) ? 1 : ((idx > OUT_DIM) ? OUT_DIM : idx);
	endfunction

	function automatic int int_abs(input int v);
		return (v < 0) ? -v : v;
	endfunction

	// plain bubble sort of the 3x3 window with the median in fifth place
	function automatic int median_at(input int r, input int c);
		int win [9];
		int n;
		int t;
		n = 0;
		for (int dr = -1; dr <= 1; dr++) begin
			for (int dc = -1; dc <= 1; dc++) begin
				win[n] = int'(image[(r + dr) * IMG_DIM + c + dc]);
				n++;
			end
		end
		for (int i = 0; i < 8; i++) begin
			for (int j = 0; j < 8 - i; j++) begin
				if (win[j] > win[j + 1]) begin
					t = win[j];
					win[j] = win[j + 1];
					win[j + 1] = t;
				end
			end
		end
		return win[4];
	endfunction

	function automatic int padded(input int r, input int c);
		return med[clamp_interior(r)][clamp_interior(c)];
	endfunction

	// median pass, padding, then sobel threshold in raster order
	function automatic void build_model();
		int gx;
		int gy;
		int k;
		for (int r = 1; r <= OUT_DIM; r++) begin
			for (int c = 1; c <= OUT_DIM; c++) begin
				med[r][c] = median_at(r, c);
			end
		end
		exp_ones = 0;
		k = 0;
		for (int r = 1; r <= OUT_DIM; r++) begin
			for (int c = 1; c <= OUT_DIM; c++) begin
				gx = padded(r - 1, c + 1) + 2 * padded(r, c + 1) + padded(r + 1, c + 1)
					- padded(r - 1, c - 1) - 2 * padded(r, c - 1) - padded(r + 1, c - 1);
				gy = padded(r + 1, c - 1) + 2 * padded(r + 1, c) + padded(r + 1, c + 1)
					- padded(r - 1, c - 1) - 2 * padded(r - 1, c) - padded(r - 1, c + 1);
				exp_bits[k] = (int_abs(gx) + int_abs(gy)) >= EDGE_THRESH;
				exp_ones += exp_bits[k] ? 1 : 0;
				k++;
			end
		end
	endfunction

	task automatic fill_random();
		for (int i = 0; i < TOTAL_PIX; i++) begin
			rng = xorshift(rng);
			image[i] = rng[11:8];
		end
	endtask

	task automatic fill_constant(input pixel_t value);
		for (int i = 0; i < TOTAL_PIX; i++) begin
			image[i] = value;
		end
	endtask

	// dark and bright stripes four columns wide
	task automatic fill_stripes();
		for (int i = 0; i < TOTAL_PIX; i++) begin
			image[i] = (((i % IMG_DIM) / 4) % 2 == 1) ? 4'hc : 4'h3;
		end
	endtask

	// one result against the model in order of arrival
	task automatic check_output();
		assert (out_idx < OUT_PIX) else begin
			count_errors++;
			$display("readable pulsed more than %0d times in one frame, at %0t", OUT_PIX,
				$time);
		end
		if (out_idx < OUT_PIX) begin
			assert (edge_out == exp_bits[out_idx]) else begin
				value_errors++;
				$display("FAILED at %0t: edge at row %0d col %0d is %0b, expected %0b", $time,
					out_idx / OUT_DIM + 1, out_idx % OUT_DIM + 1, edge_out, exp_bits[out_idx]);
			end
			out_ones += edge_out ? 1 : 0;
			out_idx++;
		end
	endtask

	// every wait goes through here so that no pulse is missed
	task automatic step();
		@(negedge clk);
		if (readable) begin
			check_output();
		end
	endtask

	task automatic load_image();
		// no ready output, so watch for the controller to return to loading
		while (i_canny_top.state != LOAD_REG) begin
			step();
		end
		out_idx = 0;
		out_ones = 0;
		for (int g = 0; g < GROUPS; g++) begin
			pixels.lane0 = image[g * LOAD_LANES];
			pixels.lane1 = image[g * LOAD_LANES + 1];
			pixels.lane2 = image[g * LOAD_LANES + 2];
			pixels.lane3 = image[g * LOAD_LANES + 3];
			pixels.lane4 = image[g * LOAD_LANES + 4];
			load_end = (g == GROUPS - 1);
			step();
		end
		load_end = 1'b0;
		pixels = '0;
	endtask

	task automatic run_frame(input string name);
		build_model();
		load_image();
		while (out_idx < OUT_PIX) begin
			step();
		end
		assert (out_ones == exp_ones) else begin
			count_errors++;
			$display("FAILED at %0t: %s frame gave %0d edge bits, expected %0d", $time, name,
				out_ones, exp_ones);
		end
	endtask

	// run limit
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: frames not finished after %0d cycles", CYCLE_LIMIT);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	initial begin
		reset = 1'b1;
		pixels = '0;
		load_end = 1'b0;
		rng = SEED;
		cycles = 0;
		out_idx = OUT_PIX;
		out_ones = 0;
		value_errors = 0;
		count_errors = 0;
		protocol_errors = 0;
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;

		// frames run back to back and share no data
		fill_random();
		run_frame("random");
		fill_constant(4'h9);
		run_frame("constant");
		fill_stripes();
		run_frame("stripes");

		// late pulses after the last frame count as extra
		while (i_canny_top.state != LOAD_REG) begin
			step();
		end
		repeat (4) step();

		protocol_errors = i_canny_top.i_canny_assert.fail_count;
		$display("errors: %0d value, %0d count, %0d protocol", value_errors, count_errors,
			protocol_errors);
		if (value_errors == 0 && count_errors == 0 && protocol_errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* tb/canny_assert.sv */
`timescale 1ns/10ps

module canny_assert (
	input logic                   clk,
	input logic                   reset,
	input canny_pkg::ctrl_state_e state,
	input logic                   load_end,
	input logic                   readable,
	input logic                   edge_out
);
	import canny_pkg::*;

	// number of assertion failures so far
	int fail_count = 0;

	// outputs cleared by every reset cycle
	reset_clears_outputs: assert property (@(posedge clk) reset |=> !readable && !edge_out)
		else begin
			fail_count++;
			$error("readable or edge_out high after a reset cycle");
		end

	// still quiet one cycle after release
	quiet_after_reset: assert property (@(posedge clk) $fell(reset) |=> !readable && !edge_out)
		else begin
			fail_count++;
			$error("readable or edge_out high in the cycle after reset");
		end

	// edge bit only together with its strobe
	edge_needs_strobe: assert property (@(posedge clk) disable iff (reset)
		edge_out |-> readable)
		else begin
			fail_count++;
			$error("edge_out high while readable is low");
		end

	no_result_while_loading: assert property (@(posedge clk) disable iff (reset)
		(state == LOAD_REG) |-> !readable)
		else begin
			fail_count++;
			$error("readable pulsed while the image was loading");
		end

	// last host group only while loading
	load_end_in_load: assert property (@(posedge clk) disable iff (reset)
		load_end |-> (state == LOAD_REG))
		else begin
			fail_count++;
			$error("load_end given outside of loading");
		end

endmodule

bind canny_top canny_assert i_canny_assert (
	.clk(clk),
	.reset(reset),
	.state(state),
	.load_end(load_end),
	.readable(readable),
	.edge_out(edge_out)
);

/* rtl/canny_top.sv */
`timescale 1ns/10ps

module canny_top (
	input  logic                    clk,
	input  logic                    reset,
	input  canny_pkg::pixel_lanes_t pixels,
	input  logic                    load_end,
	output logic                    edge_out,
	output logic                    readable
);
	import canny_pkg::*;

	ctrl_state_e state;
	op_e op;
	logic [4:0] band_row;
	logic [4:0] col;
	logic kern_en;
	logic kern_clear;
	win_col_t win_col;
	pixel_t med_pix;
	logic med_valid;
	logic med_en;
	logic sob_en;
	logic edge_bit;
	logic edge_valid;

	// only the kernel of the running pass sees the columns
	assign med_en = kern_en && (op == OP_MEDIAN);
	assign sob_en = kern_en && (op == OP_SOBEL);

	scan_ctrl i_scan_ctrl (
		.clk(clk),
		.reset(reset),
		.load_end(load_end),
		.med_valid(med_valid),
		.edge_valid(edge_valid),
		.state(state),
		.op(op),
		.band_row(band_row),
		.col(col),
		.kern_en(kern_en),
		.kern_clear(kern_clear)
	);

	frame_buffer i_frame_buffer (
		.clk(clk),
		.reset(reset),
		.state(state),
		.pixels(pixels),
		.band_row(band_row),
		.col(col),
		.med_valid(med_valid),
		.med_pix(med_pix),
		.win_col(win_col)
	);

	median_3x3 i_median_3x3 (
		.clk(clk),
		.kern_clear(kern_clear),
		.en(med_en),
		.win_col(win_col),
		.med_pix(med_pix),
		.med_valid(med_valid)
	);

	sobel_edge i_sobel_edge (
		.clk(clk),
		.kern_clear(kern_clear),
		.en(sob_en),
		.win_col(win_col),
		.edge_bit(edge_bit),
		.edge_valid(edge_valid)
	);

	// chip outputs trail the sobel kernel by one cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			readable <= 1'b0;
			edge_out <= 1'b0;
		end else begin
			readable <= edge_valid;
			edge_out <= edge_bit;
		end
	end

endmodule

/* rtl/sobel_edge.sv */
`timescale 1ns/10ps

module sobel_edge (
	input  logic                clk,
	input  logic                kern_clear,
	input  logic                en,
	input  canny_pkg::win_col_t win_col,
	output logic                edge_bit,
	output logic                edge_valid
);
	import canny_pkg::*;

	// left and centre columns held, right one is win_col
	win_col_t left_col;
	win_col_t mid_col;
	logic [1:0] seen;
	logic full;
	logic signed [MAG_W:0] gx;
	logic signed [MAG_W:0] gy;
	logic [MAG_W-1:0] mag;

	// 1-2-1 weighted sum, at most 60
	function automatic logic signed [MAG_W:0] wsum(input pixel_t a, input pixel_t b,
		input pixel_t c);
		return (MAG_W+1)'(a) + ((MAG_W+1)'(b) << 1) + (MAG_W+1)'(c);
	endfunction

	function automatic logic [MAG_W-1:0] absv(input logic signed [MAG_W:0] v);
		return (v < 0) ? MAG_W'(-v) : MAG_W'(v);
	endfunction

	assign full = en && (seen == 2'd2);

	// right column minus left column
	assign gx = wsum(win_col.top, win_col.mid, win_col.bot)
		- wsum(left_col.top, left_col.mid, left_col.bot);
	// bottom row minus top row
	assign gy = wsum(left_col.bot, mid_col.bot, win_col.bot)
		- wsum(left_col.top, mid_col.top, win_col.top);
	assign mag = absv(gx) + absv(gy);

	always_ff @(posedge clk) begin
		if (kern_clear) begin
			seen <= '0;
		end else if (en && seen != 2'd2) begin
			seen <= seen + 2'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (en) begin
			left_col <= mid_col;
			mid_col <= win_col;
		end
	end

	// single stage, threshold on the incoming window
	always_ff @(posedge clk) begin
		edge_valid <= kern_clear ? 1'b0 : full;
		edge_bit <= full && (mag >= MAG_W'(EDGE_THRESH));
	end

endmodule

/* rtl/median_3x3.sv */
`timescale 1ns/10ps

module median_3x3 (
	input  logic                clk,
	input  logic                kern_clear,
	input  logic                en,
	input  canny_pkg::win_col_t win_col,
	output canny_pkg::pixel_t   med_pix,
	output logic                med_valid
);
	import canny_pkg::*;

	// two stored columns, the third is the incoming one
	win_col_t left_col;
	win_col_t mid_col;
	logic [1:0] seen;
	logic full;
	// each column sorted, top lowest and bot highest
	win_col_t sorted [3];
	logic sort_valid;

	function automatic pixel_t min2(input pixel_t a, input pixel_t b);
		return (a < b) ? a : b;
	endfunction

	function automatic pixel_t max2(input pixel_t a, input pixel_t b);
		return (a > b) ? a : b;
	endfunction

	function automatic pixel_t med3(input pixel_t a, input pixel_t b, input pixel_t c);
		return max2(min2(a, b), min2(max2(a, b), c));
	endfunction

	function automatic win_col_t sort3(input win_col_t c);
		win_col_t s;
		s.top = min2(min2(c.top, c.mid), c.bot);
		s.mid = med3(c.top, c.mid, c.bot);
		s.bot = max2(max2(c.top, c.mid), c.bot);
		return s;
	endfunction

	// window complete when two columns are already held
	assign full = en && (seen == 2'd2);

	always_ff @(posedge clk) begin
		if (kern_clear) begin
			seen <= '0;
		end else if (en && seen != 2'd2) begin
			seen <= seen + 2'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (en) begin
			left_col <= mid_col;
			mid_col <= win_col;
		end
	end

	// stage 1, sort within each column
	always_ff @(posedge clk) begin
		sort_valid <= kern_clear ? 1'b0 : full;
		sorted[0] <= sort3(left_col);
		sorted[1] <= sort3(mid_col);
		sorted[2] <= sort3(win_col);
	end

	// stage 2, median of max-of-lows, median-of-mids, min-of-highs
	always_ff @(posedge clk) begin
		med_valid <= kern_clear ? 1'b0 : sort_valid;
		med_pix <= med3(max2(max2(sorted[0].top, sorted[1].top), sorted[2].top),
			med3(sorted[0].mid, sorted[1].mid, sorted[2].mid),
			min2(min2(sorted[0].bot, sorted[1].bot), sorted[2].bot));
	end

endmodule

/* rtl/scan_ctrl.sv */
`timescale 1ns/10ps

module scan_ctrl (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   load_end,
	input  logic                   med_valid,
	input  logic                   edge_valid,
	output canny_pkg::ctrl_state_e state,
	output canny_pkg::op_e         op,
	output logic [4:0]             band_row,
	output logic [4:0]             col,
	output logic                   kern_en,
	output logic                   kern_clear
);
	import canny_pkg::*;

	ctrl_state_e state_next;
	logic cols_done;
	logic strobe;
	logic strobe_d;
	logic band_end;
	logic pass_end;

	// result strobe of whichever kernel the pass is running
	assign strobe = (op == OP_MEDIAN) ? med_valid : edge_valid;

	// band is over once every column went out and the results stopped
	assign band_end = (state == LOAD_MOD) && cols_done && strobe_d && !strobe;

	// band below the last one would start past row 17
	assign pass_end = band_row > 5'(OUT_DIM - 1);

	// kernels drop their window before each band
	assign kern_clear = (state == PREPARE);

	always_comb begin
		state_next = state;
		case (state)
			LOAD_REG: begin
				if (load_end) begin
					state_next = SET_OP;
				end
			end
			SET_OP: begin
				state_next = PREPARE;
			end
			PREPARE: begin
				if (!pass_end) begin
					state_next = LOAD_MOD;
				end else if (op == OP_MEDIAN) begin
					state_next = WRITE_BACK;
				end else begin
					state_next = LOAD_REG;
				end
			end
			LOAD_MOD: begin
				if (band_end) begin
					state_next = PREPARE;
				end
			end
			WRITE_BACK: begin
				state_next = SET_OP;
			end
			default: begin
				state_next = LOAD_REG;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= LOAD_REG;
		end else begin
			state <= state_next;
		end
	end

	// operation sequence, idle again once the sobel pass is done
	always_ff @(posedge clk) begin
		if (reset) begin
			op <= OP_IDLE;
		end else if (state == SET_OP) begin
			case (op)
				OP_IDLE: op <= OP_MEDIAN;
				OP_MEDIAN: op <= OP_SOBEL;
				default: op <= OP_IDLE;
			endcase
		end else if (state == PREPARE && pass_end && op == OP_SOBEL) begin
			op <= OP_IDLE;
		end
	end

	// band index steps down one row per finished band
	always_ff @(posedge clk) begin
		if (reset || state == SET_OP) begin
			band_row <= '0;
		end else if (band_end) begin
			band_row <= band_row + 5'd1;
		end
	end

	// column request counter, holds at the last column
	always_ff @(posedge clk) begin
		if (reset || state == PREPARE) begin
			col <= '0;
			cols_done <= 1'b0;
		end else if (state == LOAD_MOD && !cols_done) begin
			if (col == 5'(IMG_DIM - 1)) begin
				cols_done <= 1'b1;
			end else begin
				col <= col + 5'd1;
			end
		end
	end

	// enable trails the request by the frame buffer read latency
	always_ff @(posedge clk) begin
		if (reset) begin
			kern_en <= 1'b0;
			strobe_d <= 1'b0;
		end else begin
			kern_en <= (state == LOAD_MOD) && !cols_done;
			strobe_d <= strobe;
		end
	end

endmodule

/* rtl/frame_buffer.sv */
`timescale 1ns/10ps

module frame_buffer (
	input  logic                    clk,
	input  logic                    reset,
	input  canny_pkg::ctrl_state_e  state,
	input  canny_pkg::pixel_lanes_t pixels,
	input  logic [4:0]              band_row,
	input  logic [4:0]              col,
	input  logic                    med_valid,
	input  canny_pkg::pixel_t       med_pix,
	output canny_pkg::win_col_t     win_col
);
	import canny_pkg::*;

	// working image and median results, both raster order
	pixel_t img [TOTAL_PIX];
	pixel_t res [TOTAL_PIX];

	logic [IDX_W-1:0] load_idx;
	logic [IDX_W-1:0] rd_idx;
	logic [IDX_W-1:0] wr_idx;
	logic [4:0] wr_col;

	// border row or column folds onto the nearest interior one
	function automatic int fold(input int idx);
		if (idx < 1) begin
			return 1;
		end
		if (idx > OUT_DIM) begin
			return OUT_DIM;
		end
		return idx;
	endfunction

	// top pixel of the requested band column
	assign rd_idx = IDX_W'(band_row) * IDX_W'(IMG_DIM) + IDX_W'(col);

	// load pointer, five pixels per cycle while loading
	always_ff @(posedge clk) begin
		if (reset) begin
			load_idx <= '0;
		end else if (state == LOAD_REG) begin
			load_idx <= load_idx + IDX_W'(LOAD_LANES);
		end else begin
			load_idx <= '0;
		end
	end

	// image writes: host groups, then padded write-back of the median result
	always_ff @(posedge clk) begin
		if (state == LOAD_REG) begin
			img[load_idx] <= pixels.lane0;
			img[load_idx + IDX_W'(1)] <= pixels.lane1;
			img[load_idx + IDX_W'(2)] <= pixels.lane2;
			img[load_idx + IDX_W'(3)] <= pixels.lane3;
			img[load_idx + IDX_W'(4)] <= pixels.lane4;
		end else if (state == WRITE_BACK) begin
			// interior copies straight, corners take the diagonal pixel
			for (int r = 0; r < IMG_DIM; r++) begin
				for (int c = 0; c < IMG_DIM; c++) begin
					img[r * IMG_DIM + c] <= res[fold(r) * IMG_DIM + fold(c)];
				end
			end
		end
	end

	// column read for the kernels, valid one cycle after the request
	always_ff @(posedge clk) begin
		if (state == LOAD_MOD) begin
			win_col.top <= img[rd_idx];
			win_col.mid <= img[rd_idx + IDX_W'(IMG_DIM)];
			win_col.bot <= img[rd_idx + IDX_W'(2 * IMG_DIM)];
		end
	end

	// interior raster pointer, starts at row 1 column 1
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_idx <= IDX_W'(IMG_DIM + 1);
			wr_col <= '0;
		end else if (state == SET_OP) begin
			wr_idx <= IDX_W'(IMG_DIM + 1);
			wr_col <= '0;
		end else if (med_valid) begin
			if (wr_col == 5'(OUT_DIM - 1)) begin
				// skip right border, left border of next row
				wr_col <= '0;
				wr_idx <= wr_idx + IDX_W'(3);
			end else begin
				wr_col <= wr_col + 5'd1;
				wr_idx <= wr_idx + IDX_W'(1);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (med_valid) begin
			res[wr_idx] <= med_pix;
		end
	end

endmodule

/* rtl/canny_pkg.sv */
package canny_pkg;

	// image geometry
	localparam int IMG_DIM = 20;
	localparam int PIX_W = 4;
	localparam int IDX_W = 9;
	localparam int TOTAL_PIX = IMG_DIM * IMG_DIM;
	// pixels taken per load cycle
	localparam int LOAD_LANES = 5;
	// interior side left by a 3x3 window
	localparam int OUT_DIM = IMG_DIM - 2;

	// gradient magnitude |gx|+|gy|, at most 120
	localparam int MAG_W = 7;
	localparam int EDGE_THRESH = 24;

	typedef logic [PIX_W-1:0] pixel_t;

	// one load group, lane0 lands on the lowest pixel index
	typedef struct packed {
		pixel_t lane4;
		pixel_t lane3;
		pixel_t lane2;
		pixel_t lane1;
		pixel_t lane0;
	} pixel_lanes_t;

	// one column of a three-row band, top is the band's first row
	typedef struct packed {
		pixel_t top;
		pixel_t mid;
		pixel_t bot;
	} win_col_t;

	typedef enum logic [2:0] {
		LOAD_REG = 3'd0,
		SET_OP = 3'd1,
		PREPARE = 3'd2,
		LOAD_MOD = 3'd3,
		WRITE_BACK = 3'd4
	} ctrl_state_e;

	typedef enum logic [1:0] {
		OP_IDLE = 2'd0,
		OP_MEDIAN = 2'd1,
		OP_SOBEL = 2'd2
	} op_e;

endpackage
